// File: hps_link.f
+incdir+tb
source/hps_proto_pkg.sv
source/hps_core_pkg.sv
source/uio_frame.sv
source/sd_block_port.sv
source/file_io_port.sv
source/hps_link.sv
tb/tb_hps_link.sv

// File: run_sim.sh
#!/bin/sh
# build and run the hps_link testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f hps_link.f --top-module tb_hps_link \
	&& { out=$(./obj_dir/Vtb_hps_link); echo "$out"; } \
	&& echo "$out" | grep -qx "Done: no errors" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: source/file_io_port.sv
// file-IO channel, download only, one byte per data word
// ioctl_wr pulses two clocks after the host strobe
// ioctl_wait is not checked here, the host polls it

module file_io_port import hps_proto_pkg::*, hps_core_pkg::*; (
	input  logic        clk_sys,
	input  logic        arst_n,
	input  logic        fp_enable,
	input  logic        io_strobe,
	input  word_t       hps_din,
	output word_t       fio_dout,
	output logic        ioctl_download,
	output logic [15:0] ioctl_index,
	output logic [31:0] ioctl_file_ext,
	output logic        ioctl_wr,
	output ioctl_addr_t ioctl_addr,
	output buff_data_t  ioctl_dout
);

	logic        has_cmd;
	fio_cmd_e    fio_cmd;
	logic [2:0]  word_cnt;
	ioctl_addr_t next_addr;
	logic        wr_pend;

	// nothing is read back on this channel
	assign fio_dout = '0;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			has_cmd        <= 1'b0;
			fio_cmd        <= fio_cmd_e'(16'h0000);
			word_cnt       <= '0;
			next_addr      <= '0;
			wr_pend        <= 1'b0;
			ioctl_download <= 1'b0;
			ioctl_index    <= '0;
			ioctl_file_ext <= '0;
			ioctl_wr       <= 1'b0;
			ioctl_addr     <= '0;
			ioctl_dout     <= '0;
		end else begin
			ioctl_wr <= wr_pend;
			wr_pend  <= 1'b0;

			if (!fp_enable) begin
				has_cmd <= 1'b0;
			end else if (io_strobe) begin
				if (!has_cmd) begin
					fio_cmd  <= fio_cmd_e'(hps_din);
					has_cmd  <= 1'b1;
					word_cnt <= '0;
				end else begin
					case (fio_cmd)
						// high half first
						FIO_FILE_INFO: begin
							if (!word_cnt[1]) begin
								if (word_cnt == 3'd0)
									ioctl_file_ext[31:16] <= hps_din;
								else
									ioctl_file_ext[15:0] <= hps_din;
								word_cnt <= word_cnt + 1'b1;
							end
						end

						FIO_FILE_INDEX: begin
							ioctl_index <= hps_din;
						end

						FIO_FILE_TX: begin
							if (!(&word_cnt))
								word_cnt <= word_cnt + 1'b1;
							case (word_cnt)
								3'd0: begin
									if (hps_din[7:0] != DOWNLOAD_OFF) begin
										next_addr      <= '0;
										ioctl_addr     <= '0;
										ioctl_download <= 1'b1;
									end else begin
										// leaves the final size on ioctl_addr
										if (ioctl_download)
											ioctl_addr <= next_addr;
										ioctl_download <= 1'b0;
									end
								end
								3'd1: begin
									next_addr[15:0]  <= hps_din;
									ioctl_addr[15:0] <= hps_din;
								end
								3'd2: begin
									next_addr[26:16]  <= hps_din[10:0];
									ioctl_addr[26:16] <= hps_din[10:0];
								end
								default: ;
							endcase
						end

						FIO_FILE_TX_DAT: begin
							if (ioctl_download) begin
								ioctl_addr <= next_addr;
								ioctl_dout <= hps_din[7:0];
								wr_pend    <= 1'b1;
								next_addr  <= next_addr + 1'b1;
							end
						end

						default: ;
					endcase
				end
			end
		end
	end

endmodule

// File: source/hps_core_pkg.sv
// core-side geometry of the virtual disks, sector buffer and download port
// disk count is fixed at two, blocks are 512 bytes

package hps_core_pkg;

	localparam int NUM_DISKS = 2;

	// one bit per virtual disk
	typedef logic [NUM_DISKS-1:0] disk_mask_t;

	// disk number as carried on the host bus
	typedef logic [3:0] disk_idx_t;

	// block size code, 2 is 512 bytes
	localparam logic [2:0] BLKSZ_CODE = 3'd2;

	//////////////////////////////
	// sector buffer
	typedef logic [13:0] buff_addr_t;
	typedef logic [7:0]  buff_data_t;

	//////////////////////////////
	// download port and disk addressing
	typedef logic [26:0] ioctl_addr_t;
	typedef logic [31:0] lba_t;

endpackage

// File: source/hps_link.sv
// host link top, user-IO, SD block and file-IO channels on one word bus
// io_enable and fp_enable must never be high together
// host keeps strobes at least 4 clocks apart

module hps_link import hps_proto_pkg::*, hps_core_pkg::*; (
	input  logic         clk_sys,
	input  logic         arst_n,
	input  logic         io_enable,
	input  logic         fp_enable,
	input  logic         io_strobe,
	input  word_t        hps_din,
	input  logic [127:0] status_in,
	input  logic         status_set,
	input  lba_t         sd_lba0,
	input  lba_t         sd_lba1,
	input  disk_mask_t   sd_rd,
	input  disk_mask_t   sd_wr,
	input  buff_data_t   sd_buff_din0,
	input  buff_data_t   sd_buff_din1,
	input  logic         ioctl_wait,
	output word_t        hps_dout,
	output logic         hps_wait,
	output logic [1:0]   buttons,
	output logic         forced_scandoubler,
	output logic [31:0]  joystick_0,
	output logic [31:0]  joystick_1,
	output logic [127:0] status,
	output disk_mask_t   sd_ack,
	output buff_addr_t   sd_buff_addr,
	output buff_data_t   sd_buff_dout,
	output logic         sd_buff_wr,
	output logic         ioctl_download,
	output logic [15:0]  ioctl_index,
	output logic [31:0]  ioctl_file_ext,
	output logic         ioctl_wr,
	output ioctl_addr_t  ioctl_addr,
	output buff_data_t   ioctl_dout
);

	// user-IO frame state shared with the SD channel
	logic       frame_open;
	logic       cmd_valid;
	logic       word_valid;
	frame_idx_t frame_idx;
	uio_cmd_e   frame_cmd;

	word_t uio_dout;
	word_t sd_dout;
	word_t fio_dout;

	uio_frame u_uio (
		.clk_sys            (clk_sys),
		.arst_n             (arst_n),
		.io_enable          (io_enable),
		.io_strobe          (io_strobe),
		.hps_din            (hps_din),
		.status_in          (status_in),
		.status_set         (status_set),
		.frame_open         (frame_open),
		.cmd_valid          (cmd_valid),
		.word_valid         (word_valid),
		.frame_idx          (frame_idx),
		.frame_cmd          (frame_cmd),
		.uio_dout           (uio_dout),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status)
	);

	sd_block_port u_sd (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.frame_open   (frame_open),
		.cmd_valid    (cmd_valid),
		.word_valid   (word_valid),
		.frame_idx    (frame_idx),
		.frame_cmd    (frame_cmd),
		.hps_din      (hps_din),
		.sd_lba0      (sd_lba0),
		.sd_lba1      (sd_lba1),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.sd_buff_din0 (sd_buff_din0),
		.sd_buff_din1 (sd_buff_din1),
		.sd_dout      (sd_dout),
		.sd_ack       (sd_ack),
		.sd_buff_addr (sd_buff_addr),
		.sd_buff_dout (sd_buff_dout),
		.sd_buff_wr   (sd_buff_wr)
	);

	file_io_port u_fio (
		.clk_sys        (clk_sys),
		.arst_n         (arst_n),
		.fp_enable      (fp_enable),
		.io_strobe      (io_strobe),
		.hps_din        (hps_din),
		.fio_dout       (fio_dout),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_file_ext (ioctl_file_ext),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout)
	);

	// user-IO and SD replies are zero outside their own opcodes
	assign hps_dout = fp_enable ? fio_dout : (uio_dout | sd_dout);

	assign hps_wait = ioctl_wait;

endmodule

// File: source/hps_proto_pkg.sv
// host bus word format and command opcodes for the user-IO and file-IO channels
// SD opcodes carry the disk number in the upper byte, only the low byte decodes

package hps_proto_pkg;

	typedef logic [15:0] word_t;

	// word position inside a frame, 0 is the opcode
	typedef logic [4:0] frame_idx_t;

	//////////////////////////////
	// user-IO opcodes
	typedef enum logic [15:0] {
		CMD_CFG        = 16'h0001,
		CMD_JOY0       = 16'h0002,
		CMD_JOY1       = 16'h0003,
		CMD_SD_STAT    = 16'h0016,
		CMD_SD_WRITE   = 16'h0017,
		CMD_SD_READ    = 16'h0018,
		CMD_STATUS     = 16'h001E,
		CMD_STATUS_REQ = 16'h0029
	} uio_cmd_e;

	//////////////////////////////
	// file-IO opcodes
	typedef enum logic [15:0] {
		FIO_FILE_TX     = 16'h0053,
		FIO_FILE_TX_DAT = 16'h0054,
		FIO_FILE_INDEX  = 16'h0055,
		FIO_FILE_INFO   = 16'h0056
	} fio_cmd_e;

	// sits above the change counter in the status request reply
	localparam logic [3:0] STATUS_REQ_TAG = 4'hA;

	// file-TX first byte that ends a download
	localparam logic [7:0] DOWNLOAD_OFF = 8'h00;

endpackage

// File: source/sd_block_port.sv
// SD block channel: disk arbitration, request header, sector buffer access
// buffer write strobes two clocks after the host strobe, one byte per word
// sd_ack holds until the clock after io_enable falls

module sd_block_port import hps_proto_pkg::*, hps_core_pkg::*; (
	input  logic       clk_sys,
	input  logic       arst_n,
	input  logic       frame_open,
	input  logic       cmd_valid,
	input  logic       word_valid,
	input  frame_idx_t frame_idx,
	input  uio_cmd_e   frame_cmd,
	input  word_t      hps_din,
	input  lba_t       sd_lba0,
	input  lba_t       sd_lba1,
	input  disk_mask_t sd_rd,
	input  disk_mask_t sd_wr,
	input  buff_data_t sd_buff_din0,
	input  buff_data_t sd_buff_din1,
	output word_t      sd_dout,
	output disk_mask_t sd_ack,
	output buff_addr_t sd_buff_addr,
	output buff_data_t sd_buff_dout,
	output logic       sd_buff_wr
);

	lba_t       lba_arr [NUM_DISKS];
	buff_data_t din_arr [NUM_DISKS];

	// round-robin selection
	disk_idx_t rr_ptr;
	disk_idx_t sel_disk;
	logic      sel_wr;
	logic      sel_rd;

	// disk reported by the last header, for the LBA words
	disk_idx_t stat_disk;
	lba_t      stat_lba;

	buff_data_t  ack_din;
	logic        wr_pend;
	uio_cmd_e    op_word;
	logic [15:0] req_onehot;

	assign lba_arr[0] = sd_lba0;
	assign lba_arr[1] = sd_lba1;
	assign din_arr[0] = sd_buff_din0;
	assign din_arr[1] = sd_buff_din1;

	// opcode on the bus, disk number stripped
	assign op_word    = uio_cmd_e'({8'h00, hps_din[7:0]});
	assign req_onehot = 16'd1 << hps_din[11:8];

	// first requesting disk at or after the pointer
	always_comb begin
		int n;
		sel_disk = '0;
		sel_wr   = 1'b0;
		sel_rd   = 1'b0;
		for (int i = NUM_DISKS - 1; i >= 0; i--) begin
			n = i + int'(rr_ptr);
			if (n >= NUM_DISKS)
				n = n - NUM_DISKS;
			if (sd_wr[n] || sd_rd[n]) begin
				sel_disk = disk_idx_t'(n);
				sel_wr   = sd_wr[n];
				sel_rd   = sd_rd[n];
			end
		end
	end

	always_comb begin
		stat_lba = '0;
		for (int i = 0; i < NUM_DISKS; i++) begin
			if (disk_idx_t'(i) == stat_disk)
				stat_lba = lba_arr[i];
		end
	end

	// buffer data of the acked disk
	always_comb begin
		ack_din = '0;
		for (int i = 0; i < NUM_DISKS; i++) begin
			if (sd_ack[i])
				ack_din = din_arr[i];
		end
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			sd_dout      <= '0;
			sd_ack       <= '0;
			sd_buff_addr <= '0;
			sd_buff_dout <= '0;
			sd_buff_wr   <= 1'b0;
			wr_pend      <= 1'b0;
			rr_ptr       <= '0;
			stat_disk    <= '0;
		end else begin
			// write pipeline, address moves on after each write
			wr_pend    <= 1'b0;
			sd_buff_wr <= wr_pend;
			if (sd_buff_wr && !(&sd_buff_addr))
				sd_buff_addr <= sd_buff_addr + 1'b1;

			if (!frame_open) begin
				sd_ack  <= '0;
				sd_dout <= '0;
			end else if (cmd_valid) begin
				sd_dout      <= '0;
				sd_buff_addr <= '0;
				case (op_word)
					CMD_SD_STAT: begin
						sd_dout   <= {1'b1, 6'd0, BLKSZ_CODE, sel_disk, sel_wr, sel_rd};
						stat_disk <= sel_disk;
					end
					CMD_SD_WRITE, CMD_SD_READ: begin
						sd_ack <= req_onehot[NUM_DISKS-1:0];
					end
					default: ;
				endcase
			end else if (word_valid) begin
				sd_dout <= '0;
				case (frame_cmd)
					CMD_SD_STAT: begin
						if (frame_idx == 5'd1)
							rr_ptr <= (rr_ptr == disk_idx_t'(NUM_DISKS - 1)) ? '0 : rr_ptr + 1'b1;
						else if (frame_idx == 5'd2)
							sd_dout <= stat_lba[15:0];
						else if (frame_idx == 5'd3)
							sd_dout <= stat_lba[31:16];
					end

					CMD_SD_WRITE: begin
						sd_buff_dout <= hps_din[7:0];
						wr_pend      <= 1'b1;
					end

					CMD_SD_READ: begin
						sd_dout <= {8'h00, ack_din};
						if (!(&sd_buff_addr))
							sd_buff_addr <= sd_buff_addr + 1'b1;
					end

					default: ;
				endcase
			end
		end
	end

endmodule

// File: source/uio_frame.sv
// user-IO frame tracker, also drives the frame strobes for the SD channel
// opcode is latched by its low byte only
// reply is registered and valid from the clock after a strobe

module uio_frame import hps_proto_pkg::*; (
	input  logic         clk_sys,
	input  logic         arst_n,
	input  logic         io_enable,
	input  logic         io_strobe,
	input  word_t        hps_din,
	input  logic [127:0] status_in,
	input  logic         status_set,
	output logic         frame_open,
	output logic         cmd_valid,
	output logic         word_valid,
	output frame_idx_t   frame_idx,
	output uio_cmd_e     frame_cmd,
	output word_t        uio_dout,
	output logic [1:0]   buttons,
	output logic         forced_scandoubler,
	output logic [31:0]  joystick_0,
	output logic [31:0]  joystick_1,
	output logic [127:0] status
);

	// status captured from the core, with its change counter
	logic [127:0] status_req;
	logic [3:0]   stat_cnt;
	logic         status_set_d;

	// 16-bit slot of the 128-bit status for data words 1 to 8
	logic [2:0] slot;
	logic       slot_ok;

	assign frame_open = io_enable;
	assign cmd_valid  = io_enable & io_strobe & (frame_idx == '0);
	assign word_valid = io_enable & io_strobe & (frame_idx != '0);

	assign slot    = 3'(frame_idx - 5'd1);
	assign slot_ok = (frame_idx != '0) && (frame_idx <= 5'd8);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			frame_idx          <= '0;
			frame_cmd          <= uio_cmd_e'(16'h0000);
			uio_dout           <= '0;
			buttons            <= '0;
			forced_scandoubler <= 1'b0;
			joystick_0         <= '0;
			joystick_1         <= '0;
			status             <= '0;
			status_req         <= '0;
			stat_cnt           <= '0;
			status_set_d       <= 1'b0;
		end else begin
			// core side status change, counted per rising edge
			status_set_d <= status_set;
			if (status_set && !status_set_d) begin
				status_req <= status_in;
				stat_cnt   <= stat_cnt + 1'b1;
			end

			if (!io_enable) begin
				frame_idx <= '0;
				frame_cmd <= uio_cmd_e'(16'h0000);
				uio_dout  <= '0;
			end else if (io_strobe) begin
				uio_dout <= '0;
				if (!(&frame_idx))
					frame_idx <= frame_idx + 1'b1;

				if (cmd_valid) begin
					frame_cmd <= uio_cmd_e'({8'h00, hps_din[7:0]});
					if ({8'h00, hps_din[7:0]} == CMD_STATUS_REQ)
						uio_dout <= {8'h00, STATUS_REQ_TAG, stat_cnt};
				end else begin
					case (frame_cmd)
						CMD_CFG: begin
							buttons            <= hps_din[1:0];
							forced_scandoubler <= hps_din[4];
						end

						// word 1 low half, word 2 high half
						CMD_JOY0: begin
							if (frame_idx == 5'd1)
								joystick_0[15:0] <= hps_din;
							else if (frame_idx == 5'd2)
								joystick_0[31:16] <= hps_din;
						end

						CMD_JOY1: begin
							if (frame_idx == 5'd1)
								joystick_1[15:0] <= hps_din;
							else if (frame_idx == 5'd2)
								joystick_1[31:16] <= hps_din;
						end

						CMD_STATUS: begin
							if (slot_ok)
								status[{slot, 4'b0000} +: 16] <= hps_din;
						end

						// readback of the captured value, low word first
						CMD_STATUS_REQ: begin
							if (slot_ok)
								uio_dout <= status_req[{slot, 4'b0000} +: 16];
						end

						default: ;
					endcase
				end
			end
		end
	end

endmodule

// File: tb/hps_link_cases.txt
# frames: name io|fp opcode nwords data... replies (opcode reply first); iof|fpf: LFSR data
# set and chk lines: name set|chk signal value, all numbers in hex
cfg_word     io  0001 1 0013 0 0
cfg_btn      chk buttons 3
cfg_sdbl     chk scandbl 1
joy0_write   io  0002 2 1234 abcd 0 0 0
joy0_val     chk joy0 abcd1234
joy1_write   io  0003 2 5555 00a0 0 0 0
joy1_val     chk joy1 00a05555
status_wr    io  001e 8 1111 2222 3333 4444 5555 6666 7777 8888 0 0 0 0 0 0 0 0 0
status_val   chk status 88887777666655554444333322221111
stin_first   set status_in 0123456789abcdef0011223344556677
stin_pulse1  set status_pulse 1
stin_second  set status_in fedcba98765432100f1e2d3c4b5a6978
stin_pulse2  set status_pulse 1
status_req   io  0029 8 0 0 0 0 0 0 0 0 00a2 6978 4b5a 2d3c 0f1e 3210 7654 ba98 fedc
sd_lba0      set lba0 00112233
sd_lba1      set lba1 deadbeef
sd_rd1       set sd_rd 2
sd_stat_d1   io  0016 3 0 0 0 8085 0 beef dead
sd_rd_off    set sd_rd 0
sd_wr_both   set sd_wr 3
sd_stat_rr1  io  0016 3 0 0 0 8086 0 beef dead
sd_stat_rr0  io  0016 3 0 0 0 8082 0 2233 0011
sd_wr_off    set sd_wr 0
sd_write_d1  io  0117 4 00a1 00b2 01c3 ffd4 0 0 0 0 0
sd_write_rnd iof 0117 6
sd_din1      set din1 5a
sd_read_d1   io  0118 3 0 0 0 0 005a 005a 005a
wait_on      set wait 1
wait_seen    chk wait 1
wait_off     set wait 0
fio_index    fp  0055 1 0003 0 0
fio_idx_val  chk index 0003
fio_info     fp  0056 2 4249 4e00 0 0 0
fio_ext_val  chk ext 42494e00
fio_start    fp  0053 1 0001 0 0
fio_dl_on    chk download 1
fio_data     fp  0054 4 0011 0022 0133 0044 0 0 0 0 0
fio_data_rnd fpf 0054 5
fio_stop     fp  0053 1 0000 0 0
fio_dl_off   chk download 0
fio_ignored  fp  0054 2 0077 0088 0 0 0
fio_restart  fp  0053 3 0001 0100 0000 0 0 0 0
fio_data_hi  fp  0054 2 00aa 00bb 0 0 0
fio_stop2    fp  0053 1 0000 0 0
fio_dl_end   chk download 0

// File: tb/hps_bus_tasks.svh
// host side bus tasks, included inside the testbench module
// inputs change on the falling edge, strobes are 4 clocks apart
// the reply is sampled in the last clock before the next strobe slot

`ifndef HPS_BUS_TASKS_SVH
`define HPS_BUS_TASKS_SVH

// frame opens with its enable rising
task automatic open_frame(input logic use_fp);
	@(negedge clk_sys);
	if (use_fp)
		fp_enable = 1'b1;
	else
		io_enable = 1'b1;
endtask

// one strobed word and the registered reply that follows it
task automatic strobe_word(input word_t w, output word_t reply);
	@(negedge clk_sys);
	hps_din   = w;
	io_strobe = 1'b1;
	@(negedge clk_sys);
	io_strobe = 1'b0;
	repeat (2) @(negedge clk_sys);
	reply = hps_dout;
endtask

task automatic close_frame();
	@(negedge clk_sys);
	io_enable = 1'b0;
	fp_enable = 1'b0;
	hps_din   = '0;
	@(negedge clk_sys);
endtask

`endif

// File: tb/tb_hps_link.sv
// testbench for hps_link with cases from tb/hps_link_cases.txt
// run from the project root
// stops at the first mismatch

module tb_hps_link import hps_proto_pkg::*, hps_core_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT_CYCLES = 64;
	localparam int MAX_WORDS      = 16;

	logic         clk_sys;
	logic         arst_n;
	logic         io_enable;
	logic         fp_enable;
	logic         io_strobe;
	word_t        hps_din;
	logic [127:0] status_in;
	logic         status_set;
	lba_t         sd_lba0;
	lba_t         sd_lba1;
	disk_mask_t   sd_rd;
	disk_mask_t   sd_wr;
	buff_data_t   sd_buff_din0;
	buff_data_t   sd_buff_din1;
	logic         ioctl_wait;

	word_t        hps_dout;
	logic         hps_wait;
	logic [1:0]   buttons;
	logic         forced_scandoubler;
	logic [31:0]  joystick_0;
	logic [31:0]  joystick_1;
	logic [127:0] status;
	disk_mask_t   sd_ack;
	buff_addr_t   sd_buff_addr;
	buff_data_t   sd_buff_dout;
	logic         sd_buff_wr;
	logic         ioctl_download;
	logic [15:0]  ioctl_index;
	logic [31:0]  ioctl_file_ext;
	logic         ioctl_wr;
	ioctl_addr_t  ioctl_addr;
	buff_data_t   ioctl_dout;

	// current case words and replies with the opcode reply at index 0
	word_t words     [1:MAX_WORDS];
	word_t exp_reply [0:MAX_WORDS];

	// write logs with {address, byte} entries
	logic [39:0] sd_log  [$];
	logic [39:0] fio_log [$];
	logic [39:0] exp_log [$];

	// download state as the host frames so far imply it
	logic        fio_dl;
	logic [26:0] fio_addr;

	logic [15:0] lfsr_state;
	int          cases_run;

	hps_link UUT (.*);

	`include "hps_bus_tasks.svh"

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// one entry per write pulse
	always @(negedge clk_sys) begin
		if (sd_buff_wr)
			sd_log.push_back({18'd0, sd_buff_addr, sd_buff_dout});
		if (ioctl_wr)
			fio_log.push_back({5'd0, ioctl_addr, ioctl_dout});
	end

	//////////////////////////////
	// checking

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Done: errors found");
		$fatal(1, "testbench stopped");
	endtask

	task automatic check_value(input string tag, input logic [127:0] expected,
		input logic [127:0] actual);
		if (actual !== expected)
			fail_run($sformatf("** Error %s: expected %0h, actual %0h",
				tag, expected, actual));
	endtask

	// taps for x^16 + x^14 + x^13 + x^11 + 1 when shifting right
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[0] ^ s[2] ^ s[3] ^ s[5], s[15:1]};
	endfunction

	task automatic random_word(output word_t w);
		w = '0;
		for (int b = 0; b < 16; b++) begin
			lfsr_state = lfsr_next(lfsr_state);
			w = {w[14:0], lfsr_state[0]};
		end
	endtask

	function automatic int write_count(input logic use_fp);
		if (use_fp)
			return fio_log.size();
		return sd_log.size();
	endfunction

	//////////////////////////////
	// expected writes

	// SD bytes land at 0, 1, 2 and on
	// downloads go to the running address
	task automatic expect_word(input logic use_fp, input logic [7:0] opl, input int k);
		if (!use_fp && opl == 8'h17)
			exp_log.push_back({32'(k - 1), words[k][7:0]});
		if (use_fp && opl == 8'h53) begin
			if (k == 1) begin
				fio_dl   = (words[k][7:0] != 8'h00);
				fio_addr = '0;
			end else if (k == 2) begin
				fio_addr[15:0] = words[k];
			end else if (k == 3) begin
				fio_addr[26:16] = words[k][10:0];
			end
		end
		if (use_fp && opl == 8'h54 && fio_dl) begin
			exp_log.push_back({5'd0, fio_addr, words[k][7:0]});
			fio_addr = fio_addr + 27'd1;
		end
	endtask

	task automatic wait_writes(input string tag, input logic use_fp);
		int cycles;
		cycles = 0;
		while (write_count(use_fp) < exp_log.size() || sd_ack != '0) begin
			if (cycles == TIMEOUT_CYCLES)
				fail_run({tag, ": timed out waiting for buffer writes or sd_ack release"});
			else begin
				@(negedge clk_sys);
				cycles++;
			end
		end
	endtask

	task automatic compare_writes(input string tag, input logic use_fp);
		logic [39:0] got [$];
		if (use_fp)
			got = fio_log;
		else
			got = sd_log;
		check_value({tag, " write count"}, 128'(exp_log.size()), 128'(got.size()));
		foreach (exp_log[i])
			check_value($sformatf("%s write %0d", tag, i), 128'(exp_log[i]), 128'(got[i]));
	endtask

	task automatic run_frame(input string tag, input logic use_fp, input word_t op, input int n);
		word_t      reply;
		logic [7:0] opl;
		disk_mask_t ack_exp;
		opl     = op[7:0];
		ack_exp = 2'b01 << op[11:8];
		sd_log.delete();
		fio_log.delete();
		exp_log.delete();
		open_frame(use_fp);
		strobe_word(op, reply);
		check_value({tag, " opcode reply"}, 128'(exp_reply[0]), 128'(reply));
		if (!use_fp && (opl == 8'h17 || opl == 8'h18))
			check_value({tag, " sd_ack"}, 128'(ack_exp), 128'(sd_ack));
		for (int k = 1; k <= n; k++) begin
			expect_word(use_fp, opl, k);
			strobe_word(words[k], reply);
			check_value($sformatf("%s reply %0d", tag, k), 128'(exp_reply[k]), 128'(reply));
			// read address moves on after each reply
			if (!use_fp && opl == 8'h18)
				check_value($sformatf("%s read address %0d", tag, k), 128'(k),
					128'(sd_buff_addr));
		end
		close_frame();
		wait_writes(tag, use_fp);
		compare_writes(tag, use_fp);
	endtask

	//////////////////////////////
	// cases file

	task automatic apply_input(input string sig, input logic [127:0] value);
		logic known;
		@(negedge clk_sys);
		known = 1'b1;
		if (sig == "status_in")
			status_in = value;
		else if (sig == "status_pulse") begin
			status_set = 1'b1;
			@(negedge clk_sys);
			status_set = 1'b0;
		end else if (sig == "sd_rd")
			sd_rd = value[1:0];
		else if (sig == "sd_wr")
			sd_wr = value[1:0];
		else if (sig == "lba0")
			sd_lba0 = value[31:0];
		else if (sig == "lba1")
			sd_lba1 = value[31:0];
		else if (sig == "din0")
			sd_buff_din0 = value[7:0];
		else if (sig == "din1")
			sd_buff_din1 = value[7:0];
		else if (sig == "wait")
			ioctl_wait = value[0];
		else
			known = 1'b0;
		if (!known)
			fail_run({"unknown input ", sig, " in the cases file"});
		else
			@(negedge clk_sys);
	endtask

	task automatic check_output(input string tag, input string sig, input logic [127:0] value);
		logic [127:0] actual;
		logic         known;
		@(negedge clk_sys);
		known = 1'b1;
		actual = '0;
		if (sig == "buttons")
			actual = 128'(buttons);
		else if (sig == "scandbl")
			actual = 128'(forced_scandoubler);
		else if (sig == "joy0")
			actual = 128'(joystick_0);
		else if (sig == "joy1")
			actual = 128'(joystick_1);
		else if (sig == "status")
			actual = status;
		else if (sig == "index")
			actual = 128'(ioctl_index);
		else if (sig == "ext")
			actual = 128'(ioctl_file_ext);
		else if (sig == "download")
			actual = 128'(ioctl_download);
		else if (sig == "wait")
			actual = 128'(hps_wait);
		else
			known = 1'b0;
		if (!known)
			fail_run({"unknown output ", sig, " in the cases file"});
		else
			check_value({tag, " ", sig}, value, actual);
	endtask

	// filled frames take LFSR words and expect zero replies
	task automatic load_words(input int fd, input logic fill, input int n, inout logic bad);
		int code;
		for (int k = 1; k <= n; k++) begin
			if (fill)
				random_word(words[k]);
			else begin
				code = $fscanf(fd, "%h", words[k]);
				bad  = bad || code != 1;
			end
		end
		for (int k = 0; k <= n; k++) begin
			if (fill)
				exp_reply[k] = '0;
			else begin
				code = $fscanf(fd, "%h", exp_reply[k]);
				bad  = bad || code != 1;
			end
		end
	endtask

	task automatic run_cases(input int fd);
		string        name;
		string        kind;
		string        sig;
		logic [127:0] value;
		word_t        op;
		int           n;
		int           code;
		int           ch;
		logic         bad;
		logic         use_fp;
		while ($fscanf(fd, "%s", name) == 1) begin
			if (name[0] == "#") begin
				ch = 0;
				while (ch != "\n" && ch != -1)
					ch = $fgetc(fd);
			end else begin
				code = $fscanf(fd, "%s", kind);
				bad  = (code != 1);
				cases_run++;
				if (kind == "set" || kind == "chk") begin
					code = $fscanf(fd, "%s %h", sig, value);
					bad  = bad || code != 2;
					if (bad)
						fail_run({"malformed line for case ", name});
					else if (kind == "set")
						apply_input(sig, value);
					else
						check_output(name, sig, value);
				end else if (kind == "io" || kind == "fp" || kind == "iof" || kind == "fpf") begin
					use_fp = (kind == "fp" || kind == "fpf");
					code   = $fscanf(fd, "%h %d", op, n);
					bad    = bad || code != 2 || n < 1 || n > MAX_WORDS;
					if (!bad)
						load_words(fd, kind == "iof" || kind == "fpf", n, bad);
					if (bad)
						fail_run({"malformed line for case ", name});
					else
						run_frame(name, use_fp, op, n);
				end else begin
					fail_run({"unknown case kind ", kind, " for case ", name});
				end
			end
		end
	endtask

	initial begin
		int fd;
		arst_n       = 1'b0;
		io_enable    = 1'b0;
		fp_enable    = 1'b0;
		io_strobe    = 1'b0;
		hps_din      = '0;
		status_in    = '0;
		status_set   = 1'b0;
		sd_lba0      = '0;
		sd_lba1      = '0;
		sd_rd        = '0;
		sd_wr        = '0;
		sd_buff_din0 = '0;
		sd_buff_din1 = '0;
		ioctl_wait   = 1'b0;
		lfsr_state   = 16'd9;
		fio_dl       = 1'b0;
		fio_addr     = '0;
		cases_run    = 0;

		repeat (10) @(negedge clk_sys);
		arst_n = 1'b1;
		@(negedge clk_sys);
		check_value("reset sd_ack", '0, 128'(sd_ack));
		check_value("reset sd_buff_wr", '0, 128'(sd_buff_wr));
		check_value("reset ioctl_wr", '0, 128'(ioctl_wr));
		check_value("reset ioctl_download", '0, 128'(ioctl_download));
		check_value("reset status", '0, status);
		check_value("reset hps_wait", '0, 128'(hps_wait));

		fd = $fopen("tb/hps_link_cases.txt", "r");
		if (fd == 0) begin
			fail_run("could not open tb/hps_link_cases.txt");
		end else begin
			run_cases(fd);
			$fclose(fd);
			if (cases_run == 0)
				fail_run("no cases were read from the cases file");
			else begin
				$display("Done: no errors");
				$finish;
			end
		end
	end

endmodule
